// File: design/tok_cfg_pkg.sv
`default_nettype none

package tok_cfg_pkg;

    localparam int apb_addr_w = 12;
    localparam int apb_data_w = 32;
    localparam int code_w     = 9;                 // 256 raw bytes plus vocabulary codes

    // Register window
    localparam logic [apb_addr_w-1:0] base_regs      = 12'h000;
    localparam logic [apb_addr_w-1:0] addr_ctrl      = 12'h000;
    localparam logic [apb_addr_w-1:0] addr_status    = 12'h004;
    localparam logic [apb_addr_w-1:0] addr_text_len  = 12'h008;
    localparam logic [apb_addr_w-1:0] addr_tok_count = 12'h00C;

    // Buffer windows decoded on address bits 11:10
    localparam logic [apb_addr_w-1:0] base_text  = 12'h400;
    localparam logic [apb_addr_w-1:0] base_vocab = 12'h800;
    localparam logic [apb_addr_w-1:0] base_code  = 12'hC00;

    typedef struct packed {
        logic done;                                // Bit 1
        logic busy;                                // Bit 0
    } status_t;

endpackage

`default_nettype wire

// File: design/tok_data_pkg.sv
`default_nettype none

package tok_data_pkg;

    localparam int tok_max_len = 4;

    typedef logic [7:0] text_byte_t;

    typedef logic [tok_cfg_pkg::code_w-1:0] code_t;

    // First byte sits in the most significant position
    typedef struct packed {
        logic [2:0]                         len;   // 0 marks an unused entry
        text_byte_t [0:tok_max_len-1]       bytes;
    } vocab_entry_t;

    typedef struct packed {
        logic [2:0]                         avail; // Valid bytes from the current position
        text_byte_t [0:tok_max_len-1]       bytes;
    } window_t;

    typedef struct packed {
        code_t      code;
        logic [2:0] len;                           // Bytes consumed by this token
    } token_t;

endpackage

`default_nettype wire

// File: design/tok_sram.sv
`timescale 1ns/1ps
`default_nettype none

module tok_sram #(
    parameter int  depth     = 64,
    parameter type payload_t = logic [7:0]
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(depth)-1:0] waddr,
    input  payload_t                 wdata,
    input  logic [$clog2(depth)-1:0] raddr,
    output payload_t                 rdata
);

    payload_t mem [depth];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr];                       // Registered read port
    end

endmodule

`default_nettype wire

// File: design/tok_apb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module tok_apb_regs #(
    parameter int text_depth  = 64,
    parameter int vocab_depth = 16
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic [tok_cfg_pkg::apb_addr_w-1:0]    paddr,
    input  logic                                  psel,
    input  logic                                  penable,
    input  logic                                  pwrite,
    input  logic [tok_cfg_pkg::apb_data_w-1:0]    pwdata,
    output logic [tok_cfg_pkg::apb_data_w-1:0]    prdata,
    output logic                                  pready,
    output logic                                  pslverr,
    output logic                                  text_we,
    output logic [$clog2(text_depth)-1:0]         text_waddr,
    output tok_data_pkg::text_byte_t              text_wdata,
    output logic                                  vocab_we,
    output logic [$clog2(vocab_depth)-1:0]        vocab_waddr,
    output tok_data_pkg::vocab_entry_t            vocab_wdata,
    output logic [$clog2(text_depth)-1:0]         code_raddr,
    input  tok_data_pkg::code_t                   code_rdata,
    output logic                                  start,
    output logic [$clog2(text_depth+1)-1:0]       text_len,
    input  logic                                  run_done,
    input  logic [$clog2(text_depth+1)-1:0]       tok_count
);

    import tok_cfg_pkg::*;

    localparam int addr_w = $clog2(text_depth);
    localparam int vidx_w = $clog2(vocab_depth);
    localparam int len_w  = $clog2(text_depth + 1);

    logic [1:0]       win_sel;
    logic [7:0]       word_idx;
    logic [6:0]       entry_idx;
    logic             access;
    logic             code_rd;
    logic             code_wait;
    logic             bad_addr;
    logic             bad_wr;
    logic             wr_ok;
    logic             start_wr;
    status_t          status;
    logic [len_w-1:0] count_q;
    logic [31:0]      vocab_bytes;

    assign win_sel   = paddr[11:10];
    assign word_idx  = paddr[9:2];
    assign entry_idx = paddr[9:3];                 // Two words per vocabulary entry
    assign access    = psel && penable;
    assign code_rd   = (win_sel == base_code[11:10]) && !pwrite;
    assign pready    = access && (!code_rd || code_wait);
    assign pslverr   = pready && (bad_addr || bad_wr);
    assign wr_ok     = pready && pwrite && !bad_addr && !bad_wr;
    assign start_wr  = wr_ok && (paddr == addr_ctrl) && pwdata[0];

    always_comb begin
        bad_addr = 1'b0;
        bad_wr   = 1'b0;
        case (win_sel)
            base_text[11:10]: begin
                bad_addr = word_idx >= text_depth;
                bad_wr   = pwrite && status.busy;
            end
            base_vocab[11:10]: begin
                bad_addr = entry_idx >= vocab_depth;
                bad_wr   = pwrite && status.busy;
            end
            base_code[11:10]: begin
                bad_addr = word_idx >= text_depth;
                bad_wr   = pwrite;                 // Code window is read-only
            end
            default: begin
                case (paddr)
                    addr_ctrl:      bad_wr = pwrite && status.busy;
                    addr_status:    bad_wr = 1'b0;
                    addr_text_len:  bad_wr = pwrite && (status.busy || pwdata == '0
                                             || pwdata > text_depth);
                    addr_tok_count: bad_wr = pwrite;
                    default:        bad_addr = 1'b1;
                endcase
            end
        endcase
    end

    assign text_we     = wr_ok && (win_sel == base_text[11:10]);
    assign text_waddr  = addr_w'(word_idx);
    assign text_wdata  = pwdata[7:0];
    assign vocab_we    = wr_ok && (win_sel == base_vocab[11:10]) && paddr[2];
    assign vocab_waddr = vidx_w'(entry_idx);
    assign vocab_wdata = {pwdata[2:0], vocab_bytes}; // Length word commits the entry
    assign code_raddr  = addr_w'(word_idx);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            code_wait <= 1'b0;
            start     <= 1'b0;
            status    <= '0;
            text_len  <= '0;
            count_q   <= '0;
        end else begin
            code_wait <= access && code_rd && !code_wait;
            start     <= start_wr;
            if (start_wr) begin
                status.busy <= 1'b1;
                status.done <= 1'b0;
                count_q     <= '0;
            end else if (run_done) begin
                status.busy <= 1'b0;
                status.done <= 1'b1;
                count_q     <= tok_count;
            end
            if (wr_ok && paddr == addr_text_len) begin
                text_len <= len_w'(pwdata);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_ok && win_sel == base_vocab[11:10] && !paddr[2]) begin
            vocab_bytes <= pwdata;
        end
    end

    always_comb begin
        prdata = '0;
        if (win_sel == base_code[11:10]) begin
            prdata = 32'(code_rdata);
        end else if (win_sel == base_regs[11:10]) begin
            case (paddr)
                addr_status:    prdata = 32'(status);
                addr_text_len:  prdata = 32'(text_len);
                addr_tok_count: prdata = 32'(count_q);
                default:        prdata = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/tok_char_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module tok_char_fetch #(
    parameter int text_depth = 64
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                start,
    input  logic [$clog2(text_depth+1)-1:0]     text_len,
    output logic [$clog2(text_depth)-1:0]       text_raddr,
    input  tok_data_pkg::text_byte_t            text_rdata,
    output tok_data_pkg::window_t               win,
    output logic                                win_valid,
    input  logic                                win_ready,
    input  logic                                adv_valid,
    input  logic [2:0]                          adv_len
);

    import tok_data_pkg::*;

    localparam int addr_w = $clog2(text_depth);
    localparam int len_w  = $clog2(text_depth + 1);

    typedef enum logic [1:0] {f_idle, f_read, f_valid, f_wait} fetch_state_t;

    fetch_state_t     state;
    logic [len_w-1:0] pos;
    logic [len_w-1:0] next_pos;
    logic [len_w-1:0] rem;
    logic [2:0]       next_avail;
    logic [2:0]       cnt;
    logic             load;

    assign next_pos   = start ? '0 : pos + len_w'(adv_len);
    assign rem        = text_len - next_pos;
    assign next_avail = (rem > tok_max_len) ? 3'(tok_max_len) : rem[2:0];
    assign load       = (state == f_idle && start)
                     || (state == f_wait && adv_valid && next_pos < text_len);
    assign text_raddr = addr_w'(pos + len_w'(cnt));
    assign win_valid  = state == f_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= f_idle;
            pos   <= '0;
            cnt   <= '0;
        end else begin
            case (state)
                f_idle: begin
                    if (start) begin
                        pos   <= next_pos;
                        cnt   <= '0;
                        state <= f_read;
                    end
                end
                f_read: begin
                    cnt <= cnt + 3'd1;
                    if (cnt == win.avail) begin // Last byte lands this cycle
                        state <= f_valid;
                    end
                end
                f_valid: begin
                    if (win_ready) begin
                        state <= f_wait;
                    end
                end
                default: begin
                    if (adv_valid) begin
                        pos   <= next_pos;
                        cnt   <= '0;
                        state <= load ? f_read : f_idle; // End of text
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            win.bytes <= '0;
            win.avail <= next_avail;
        end else if (state == f_read && cnt != 3'd0) begin
            win.bytes[2'(cnt - 3'd1)] <= text_rdata;
        end
    end

endmodule

`default_nettype wire

// File: design/tok_vocab_match.sv
`timescale 1ns/1ps
`default_nettype none

module tok_vocab_match #(
    parameter int vocab_depth = 16
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  tok_data_pkg::window_t               win,
    input  logic                                win_valid,
    output logic                                win_ready,
    output logic [$clog2(vocab_depth)-1:0]      vocab_raddr,
    input  tok_data_pkg::vocab_entry_t          vocab_rdata,
    output tok_data_pkg::token_t                tok,
    output logic                                tok_valid,
    input  logic                                tok_ready,
    output logic                                adv_valid,
    output logic [2:0]                          adv_len
);

    import tok_data_pkg::*;

    localparam int idx_w = $clog2(vocab_depth);
    localparam int cnt_w = $clog2(vocab_depth + 1);

    typedef enum logic [1:0] {m_idle, m_scan, m_offer} match_state_t;

    match_state_t     state;
    window_t          win_q;
    logic [cnt_w-1:0] scan_cnt;
    logic             scan_last;
    logic [idx_w-1:0] cur_idx;
    logic             hit;
    logic [2:0]       best_len;
    logic [idx_w-1:0] best_idx;
    logic [2:0]       cand_len;
    logic [idx_w-1:0] cand_idx;

    assign win_ready   = state == m_idle;
    assign tok_valid   = state == m_offer;
    assign adv_valid   = tok_valid && tok_ready;
    assign adv_len     = tok.len;
    assign vocab_raddr = idx_w'(scan_cnt);
    assign cur_idx     = idx_w'(scan_cnt - 1'b1); // Entry whose data arrives now
    assign scan_last   = scan_cnt == cnt_w'(vocab_depth);

    // Strictly longer only, so the earliest entry keeps a tie
    always_comb begin
        hit = vocab_rdata.len != 3'd0
           && vocab_rdata.len <= win_q.avail
           && vocab_rdata.len > best_len;
        for (int k = 0; k < tok_max_len; k++) begin
            if (k < vocab_rdata.len && vocab_rdata.bytes[k] != win_q.bytes[k]) begin
                hit = 1'b0;
            end
        end
    end

    assign cand_len = (scan_cnt != '0 && hit) ? vocab_rdata.len : best_len;
    assign cand_idx = (scan_cnt != '0 && hit) ? cur_idx : best_idx;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= m_idle;
            scan_cnt <= '0;
        end else begin
            case (state)
                m_idle: begin
                    scan_cnt <= '0;
                    if (win_valid) begin
                        state <= m_scan;
                    end
                end
                m_scan: begin
                    scan_cnt <= scan_cnt + 1'b1;
                    if (scan_last) begin
                        state <= m_offer;
                    end
                end
                default: begin
                    if (tok_ready) begin
                        state <= m_idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (win_valid && win_ready) begin
            win_q    <= win;
            best_len <= '0;
            best_idx <= '0;
        end else if (state == m_scan) begin
            best_len <= cand_len;
            best_idx <= cand_idx;
            if (scan_last) begin
                if (cand_len != 3'd0) begin
                    tok.code <= code_t'(256 + cand_idx);
                    tok.len  <= cand_len;
                end else begin
                    tok.code <= code_t'(win_q.bytes[0]); // Raw byte fallback
                    tok.len  <= 3'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: design/tok_code_emit.sv
`timescale 1ns/1ps
`default_nettype none

module tok_code_emit #(
    parameter int text_depth = 64
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                start,
    input  logic [$clog2(text_depth+1)-1:0]     text_len,
    input  tok_data_pkg::token_t                tok,
    input  logic                                tok_valid,
    output logic                                tok_ready,
    output logic                                code_we,
    output logic [$clog2(text_depth)-1:0]       code_waddr,
    output tok_data_pkg::code_t                 code_wdata,
    output logic                                run_done,
    output logic [$clog2(text_depth+1)-1:0]     tok_count
);

    localparam int addr_w = $clog2(text_depth);
    localparam int len_w  = $clog2(text_depth + 1);

    logic             running;
    logic             accept;
    logic [len_w-1:0] consumed;
    logic [len_w-1:0] consumed_nxt;

    assign tok_ready    = running;
    assign accept       = tok_valid && tok_ready;
    assign code_we      = accept;
    assign code_waddr   = addr_w'(tok_count);
    assign code_wdata   = tok.code;
    assign consumed_nxt = consumed + len_w'(tok.len);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            running   <= 1'b0;
            tok_count <= '0;
            consumed  <= '0;
            run_done  <= 1'b0;
        end else begin
            run_done <= accept && consumed_nxt == text_len; // Last code just written
            if (start) begin
                running   <= 1'b1;
                tok_count <= '0;
                consumed  <= '0;
            end else if (accept) begin
                tok_count <= tok_count + 1'b1;
                consumed  <= consumed_nxt;
                if (consumed_nxt == text_len) begin
                    running <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: design/tok_encoder_top.sv
`timescale 1ns/1ps
`default_nettype none

module tok_encoder_top #(
    parameter int text_depth  = 64,
    parameter int vocab_depth = 16
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [tok_cfg_pkg::apb_addr_w-1:0]  paddr,
    input  logic                                psel,
    input  logic                                penable,
    input  logic                                pwrite,
    input  logic [tok_cfg_pkg::apb_data_w-1:0]  pwdata,
    output logic [tok_cfg_pkg::apb_data_w-1:0]  prdata,
    output logic                                pready,
    output logic                                pslverr
);

    import tok_data_pkg::*;

    localparam int addr_w = $clog2(text_depth);
    localparam int vidx_w = $clog2(vocab_depth);
    localparam int len_w  = $clog2(text_depth + 1);

    logic              text_we;
    logic [addr_w-1:0] text_waddr;
    text_byte_t        text_wdata;
    logic [addr_w-1:0] text_raddr;
    text_byte_t        text_rdata;
    logic              vocab_we;
    logic [vidx_w-1:0] vocab_waddr;
    vocab_entry_t      vocab_wdata;
    logic [vidx_w-1:0] vocab_raddr;
    vocab_entry_t      vocab_rdata;
    logic              code_we;
    logic [addr_w-1:0] code_waddr;
    code_t             code_wdata;
    logic [addr_w-1:0] code_raddr;
    code_t             code_rdata;
    logic              start;
    logic [len_w-1:0]  text_len;
    logic              run_done;
    logic [len_w-1:0]  tok_count;
    window_t           win;
    logic              win_valid;
    logic              win_ready;
    logic              adv_valid;
    logic [2:0]        adv_len;
    token_t            tok;
    logic              tok_valid;
    logic              tok_ready;

    tok_apb_regs #(.text_depth(text_depth), .vocab_depth(vocab_depth)) apb_regs (
        .clk(clk), .rst_n(rst_n),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .text_we(text_we), .text_waddr(text_waddr), .text_wdata(text_wdata),
        .vocab_we(vocab_we), .vocab_waddr(vocab_waddr), .vocab_wdata(vocab_wdata),
        .code_raddr(code_raddr), .code_rdata(code_rdata),
        .start(start), .text_len(text_len), .run_done(run_done), .tok_count(tok_count)
    );

    tok_char_fetch #(.text_depth(text_depth)) char_fetch (
        .clk(clk), .rst_n(rst_n), .start(start), .text_len(text_len),
        .text_raddr(text_raddr), .text_rdata(text_rdata),
        .win(win), .win_valid(win_valid), .win_ready(win_ready),
        .adv_valid(adv_valid), .adv_len(adv_len)
    );

    tok_vocab_match #(.vocab_depth(vocab_depth)) vocab_match (
        .clk(clk), .rst_n(rst_n),
        .win(win), .win_valid(win_valid), .win_ready(win_ready),
        .vocab_raddr(vocab_raddr), .vocab_rdata(vocab_rdata),
        .tok(tok), .tok_valid(tok_valid), .tok_ready(tok_ready),
        .adv_valid(adv_valid), .adv_len(adv_len)
    );

    tok_code_emit #(.text_depth(text_depth)) code_emit (
        .clk(clk), .rst_n(rst_n), .start(start), .text_len(text_len),
        .tok(tok), .tok_valid(tok_valid), .tok_ready(tok_ready),
        .code_we(code_we), .code_waddr(code_waddr), .code_wdata(code_wdata),
        .run_done(run_done), .tok_count(tok_count)
    );

    tok_sram #(.depth(text_depth), .payload_t(text_byte_t)) text_buf (
        .clk(clk), .we(text_we), .waddr(text_waddr), .wdata(text_wdata),
        .raddr(text_raddr), .rdata(text_rdata)
    );

    tok_sram #(.depth(vocab_depth), .payload_t(vocab_entry_t)) vocab_buf (
        .clk(clk), .we(vocab_we), .waddr(vocab_waddr), .wdata(vocab_wdata),
        .raddr(vocab_raddr), .rdata(vocab_rdata)
    );

    tok_sram #(.depth(text_depth), .payload_t(code_t)) code_buf (
        .clk(clk), .we(code_we), .waddr(code_waddr), .wdata(code_wdata),
        .raddr(code_raddr), .rdata(code_rdata)
    );

endmodule

`default_nettype wire

// File: verification/tok_encoder_tb.sv
`timescale 1ns/1ps
`default_nettype none

module tok_encoder_tb;

    import tok_cfg_pkg::*;

    localparam int text_depth  = 64;
    localparam int vocab_depth = 16;
    localparam int apb_limit   = 20;
    localparam int poll_limit  = 4000;

    logic        clk;
    logic        rst_n;
    logic [11:0] paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    logic [31:0] lfsr;
    int          n_checks;
    int          n_errors;
    logic [7:0]  txt [text_depth];
    int          txt_n;
    int          voc_len [vocab_depth];
    logic [7:0]  voc_b [vocab_depth][4];
    logic [31:0] exp_code [text_depth];
    int          exp_n;

    tok_encoder_top #(.text_depth(text_depth), .vocab_depth(vocab_depth)) tok_encoder_top_inst (
        .clk(clk), .rst_n(rst_n),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
        n_checks++;
        assert (got === exp) else begin
            n_errors++;
            $display("[ERROR] %0t %s got 0x%0h expected 0x%0h", $time, what, got, exp);
        end
    endtask

    task automatic give_up(input string why);
        n_errors++;
        $display("Timeout at %0t: %s", $time, why);
        $display("Checks: %0d, errors: %0d", n_checks, n_errors);
        $display("TEST FAIL");
        $finish;
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    task automatic apb_xfer(input logic [11:0] addr, input logic wr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err, output int waits);
        int n;
        @(posedge clk);
        paddr   <= addr;
        pwrite  <= wr;
        pwdata  <= wdata;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        n = 0;
        @(negedge clk);
        while (!pready && n < apb_limit) begin
            @(negedge clk);
            n++;
        end
        if (!pready) begin
            give_up("APB transfer never saw pready");
        end else begin
            waits = n;
            rdata = prdata;
            err   = pslverr;
            @(posedge clk);
            psel    <= 1'b0;
            penable <= 1'b0;
        end
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data, input logic bad);
        logic [31:0] d;
        logic        e;
        int          w;
        apb_xfer(addr, 1'b1, data, d, e, w);
        check_eq("pslverr", e, bad);
    endtask

    task automatic apb_read(input logic [11:0] addr, input int exp_waits, output logic [31:0] d);
        logic e;
        int   w;
        apb_xfer(addr, 1'b0, '0, d, e, w);
        check_eq("pslverr", e, 1'b0);
        check_eq("pready wait cycles", w, exp_waits);
    endtask

    task automatic set_text(input string s);
        txt_n = s.len();
        for (int i = 0; i < txt_n; i++) begin
            txt[i] = s[i];
        end
    endtask

    task automatic set_entry(input int i, input string s);
        voc_len[i] = s.len();
        for (int k = 0; k < 4; k++) begin
            voc_b[i][k] = (k < s.len()) ? s[k] : 8'h00;
        end
    endtask

    task automatic load_buffers();
        for (int i = 0; i < txt_n; i++) begin
            apb_write(base_text + 12'(4 * i), 32'(txt[i]), 1'b0);
        end
        for (int i = 0; i < vocab_depth; i++) begin
            apb_write(base_vocab + 12'(8 * i),
                      {voc_b[i][0], voc_b[i][1], voc_b[i][2], voc_b[i][3]}, 1'b0);
            apb_write(base_vocab + 12'(8 * i + 4), 32'(voc_len[i]), 1'b0);
        end
    endtask

    // Greedy longest match, lowest index on a tie, raw byte otherwise
    task automatic ref_encode();
        int p;
        int avail;
        int best_len;
        int best_idx;
        bit ok;
        p = 0;
        exp_n = 0;
        while (p < txt_n) begin
            avail = (txt_n - p > 4) ? 4 : txt_n - p;
            best_len = 0;
            best_idx = 0;
            for (int i = 0; i < vocab_depth; i++) begin
                ok = voc_len[i] > best_len && voc_len[i] <= avail;
                for (int k = 0; k < 4; k++) begin
                    if (ok && k < voc_len[i] && voc_b[i][k] != txt[p + k]) begin
                        ok = 1'b0;
                    end
                end
                if (ok) begin
                    best_len = voc_len[i];
                    best_idx = i;
                end
            end
            exp_code[exp_n] = (best_len == 0) ? 32'(txt[p]) : 32'(256 + best_idx);
            exp_n++;
            p += (best_len == 0) ? 1 : best_len;
        end
    endtask

    task automatic start_run();
        logic [31:0] d;
        apb_write(addr_text_len, 32'(txt_n), 1'b0);
        apb_write(addr_ctrl, 32'h1, 1'b0);
        apb_read(addr_status, 0, d);
        check_eq("status after start", d, 32'h1);     // Busy set, done cleared
    endtask

    task automatic wait_done();
        logic [31:0] d;
        int          n;
        n = 0;
        d = '0;
        while (!d[1] && n < poll_limit) begin
            apb_read(addr_status, 0, d);
            check_eq("status busy xor done", d[0] ^ d[1], 1'b1);
            n++;
        end
        if (!d[1]) begin
            give_up("done never rose");
        end
    endtask

    task automatic check_codes();
        logic [31:0] d;
        ref_encode();
        apb_read(addr_tok_count, 0, d);
        check_eq("tok_count", d, 32'(exp_n));
        for (int i = 0; i < exp_n; i++) begin
            apb_read(base_code + 12'(4 * i), 1, d);   // Code window has one wait state
            check_eq($sformatf("code[%0d]", i), d, exp_code[i]);
        end
    endtask

    initial begin
        logic [31:0] d;
        rst_n   = 1'b0;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        lfsr    = 32'd76217;
        n_checks = 0;
        n_errors = 0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        apb_read(addr_status, 0, d);
        check_eq("status after reset", d, 32'h0);
        apb_read(addr_tok_count, 0, d);
        check_eq("tok_count after reset", d, 32'h0);

        // Shared prefixes, a duplicate pair, raw bytes and a long entry near the end
        set_text("then the hex!the");
        set_entry(0, "th");
        set_entry(1, "then");
        set_entry(2, "t");
        set_entry(3, "the");
        set_entry(4, "he");
        set_entry(5, "e ");
        set_entry(6, "he");
        for (int i = 7; i < vocab_depth; i++) begin
            set_entry(i, "");
        end
        load_buffers();
        start_run();
        wait_done();
        check_codes();

        // Second run, rejected writes while busy
        start_run();
        apb_read(addr_tok_count, 0, d);
        check_eq("tok_count after restart", d, 32'h0);
        apb_write(base_text, 32'h7a, 1'b1);
        apb_write(base_vocab + 12'h8, 32'h7a7a7a7a, 1'b1);
        apb_write(base_vocab + 12'hC, 32'h4, 1'b1);
        wait_done();
        check_codes();

        apb_write(12'h010, 32'h1, 1'b1);
        apb_write(addr_text_len, 32'h0, 1'b1);
        apb_write(addr_text_len, 32'(text_depth + 1), 1'b1);
        apb_read(addr_text_len, 0, d);
        check_eq("text_len", d, 32'(txt_n));
        apb_write(addr_tok_count, 32'h5, 1'b1);
        apb_read(addr_tok_count, 0, d);
        check_eq("tok_count", d, 32'(exp_n));
        start_run();                                  // Buffers must be untouched
        wait_done();
        check_codes();

        for (int r = 0; r < 4; r++) begin
            txt_n = 24 + take_bits(5);
            for (int i = 0; i < txt_n; i++) begin
                txt[i] = 8'h61 + 8'(2 * take_bits(2));
            end
            for (int i = 0; i < vocab_depth; i++) begin
                voc_len[i] = take_bits(3) % 5;
                for (int k = 0; k < 4; k++) begin
                    voc_b[i][k] = 8'h61 + 8'(2 * take_bits(2));
                end
            end
            load_buffers();
            start_run();
            wait_done();
            check_codes();
        end

        $display("Checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
design/tok_cfg_pkg.sv
design/tok_data_pkg.sv
design/tok_sram.sv
design/tok_apb_regs.sv
design/tok_char_fetch.sv
design/tok_vocab_match.sv
design/tok_code_emit.sv
design/tok_encoder_top.sv
verification/tok_encoder_tb.sv

// File: Bender.yml
package:
  name: tok_encoder

sources:
  - design/tok_cfg_pkg.sv
  - design/tok_data_pkg.sv
  - design/tok_sram.sv
  - design/tok_apb_regs.sv
  - design/tok_char_fetch.sv
  - design/tok_vocab_match.sv
  - design/tok_code_emit.sv
  - design/tok_encoder_top.sv
  - target: test
    files:
      - verification/tok_encoder_tb.sv
